/* smu_ctl_pkg.sv */
/*
 * shared definitions for the smu control-register bank
 * frame widths, register addresses, reset values, field types
 */

`default_nettype none

package smu_ctl_pkg;

  ////////////////////
  // frame format

  // one spi frame, address byte then value byte
  localparam int frame_bits = 16;

  // high byte of the frame
  typedef logic [7:0] addr_t;

  // low byte of the frame
  // bits 3..0 set, bits 7..4 clear
  typedef logic [7:0] val_t;

  // every control register is one nibble
  // keeps set/clear halves of val_t aligned with the register
  typedef logic [3:0] ctl_t;

  ////////////////////
  // register map

  localparam addr_t addr_led         = 8'd7;
  localparam addr_t addr_mux         = 8'd8;
  localparam addr_t addr_dac         = 8'd9;
  localparam addr_t addr_rails       = 8'd10;
  // write of any value reloads every register
  localparam addr_t addr_soft_reset  = 8'd11;
  localparam addr_t addr_dac_ref_mux = 8'd12;
  // 13 unused
  localparam addr_t addr_adc         = 8'd14;
  localparam addr_t addr_clamp1      = 8'd15;
  localparam addr_t addr_clamp2      = 8'd16;
  localparam addr_t addr_rails_oe    = 8'd24;

  ////////////////////
  // reset values

  // led, mux, dac, rails, dac ref mux, adc
  localparam ctl_t rst_default  = 4'b0000;

  // clamp switches are active low
  // all ones leaves them off
  localparam ctl_t rst_clamp1   = 4'b1111;
  localparam ctl_t rst_clamp2   = 4'b1111;

  // rails output enable is active low on bit 0
  // rails stay disabled until firmware turns them on
  localparam ctl_t rst_rails_oe = 4'b0001;

endpackage

`default_nettype wire

/* spi_frame_decode.sv */
/*
 * spi frame decode, pins sampled in the clk domain
 * shifts in 16-bit frames, checks length on cs_n release
 * offers finished frames over a four-phase req/ack handshake
 */

`timescale 1ns/1ps
`default_nettype none

module spi_frame_decode
  import smu_ctl_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  sclk,
  input  logic  cs_n,
  input  logic  special_n,
  input  logic  mosi,
  input  logic  frame_ack,
  output logic  frame_req,
  output addr_t frame_addr,
  output val_t  frame_val
);

  // counter saturates one past a full frame
  // so long frames never wrap back to a valid count
  localparam int               cnt_w    = $clog2(frame_bits + 2);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(frame_bits);
  localparam logic [cnt_w-1:0] cnt_over = cnt_w'(frame_bits + 1);

  // synchronizer stages, _d is the edge-detect copy
  logic sclk_s1, sclk_s2, sclk_d;
  logic cs_s1, cs_s2, cs_d;
  logic spec_s1, spec_s2;
  logic mosi_s1, mosi_s2;

  logic                  sclk_rise;
  logic                  cs_rise;
  logic [frame_bits-1:0] shift_q;
  logic [cnt_w-1:0]      bit_cnt;
  logic                  frame_done;
  logic                  take_frame;

  ////////////////////
  // pin synchronizers

  // idle levels on reset, cs_n and special_n high
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_s1 <= 1'b0;
      sclk_s2 <= 1'b0;
      sclk_d  <= 1'b0;
      cs_s1   <= 1'b1;
      cs_s2   <= 1'b1;
      cs_d    <= 1'b1;
      spec_s1 <= 1'b1;
      spec_s2 <= 1'b1;
    end
    else
    begin
      sclk_s1 <= sclk;
      sclk_s2 <= sclk_s1;
      sclk_d  <= sclk_s2;
      cs_s1   <= cs_n;
      cs_s2   <= cs_s1;
      cs_d    <= cs_s2;
      spec_s1 <= special_n;
      spec_s2 <= spec_s1;
    end
  end

  // data line, same depth as sclk so it lines up with the edge
  always_ff @(posedge clk)
  begin
    mosi_s1 <= mosi;
    mosi_s2 <= mosi_s1;
  end

  assign sclk_rise = sclk_s2 & ~sclk_d;
  assign cs_rise   = cs_s2 & ~cs_d;

  ////////////////////
  // shift in

  // only bits clocked with special_n low count
  // a frame sent with special_n high ends at zero and is dropped
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (cs_s2)
      bit_cnt <= '0;
    else if (sclk_rise && !spec_s2 && bit_cnt != cnt_over)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first, new bit enters at the bottom
  always_ff @(posedge clk)
  begin
    if (!cs_s2 && !spec_s2 && sclk_rise)
      shift_q <= {shift_q[frame_bits-2:0], mosi_s2};
  end

  // frame check on cs_n release, one cycle after the edge
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      frame_done <= 1'b0;
    else
      frame_done <= cs_rise && (bit_cnt == cnt_full);
  end

  ////////////////////
  // req side of handshake

  // a frame that lands while req or ack is still up is lost
  assign take_frame = frame_done && !frame_req && !frame_ack;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      frame_req <= 1'b0;
    else if (frame_req && frame_ack)
      frame_req <= 1'b0;
    else if (take_frame)
      frame_req <= 1'b1;
  end

  // held stable for the whole request
  always_ff @(posedge clk)
  begin
    if (take_frame)
    begin
      frame_addr <= shift_q[frame_bits-1 -: $bits(addr_t)];
      frame_val  <= shift_q[$bits(val_t)-1:0];
    end
  end

endmodule

`default_nettype wire

/* ctl_reg_execute.sv */
/*
 * control register bank, ack side of the frame handshake
 * set/clear/toggle update per register, soft reset on address 11
 */

`timescale 1ns/1ps
`default_nettype none

module ctl_reg_execute
  import smu_ctl_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  frame_req,
  input  addr_t frame_addr,
  input  val_t  frame_val,
  output logic  frame_ack,
  output ctl_t  reg_mux,
  output ctl_t  led,
  output ctl_t  dac,
  output ctl_t  rails,
  output ctl_t  dac_ref_mux,
  output ctl_t  adc,
  output ctl_t  clamp1,
  output ctl_t  clamp2,
  output ctl_t  rails_oe
);

  logic new_req;
  logic soft_rst;

  ////////////////////
  // update rule

  // set nibble low, clear nibble high
  // overlap means toggle those bits and leave the rest
  function automatic ctl_t update(input ctl_t cur, input val_t val);
    ctl_t set_b;
    ctl_t clr_b;
    ctl_t both;
    set_b = val[$bits(ctl_t)-1:0];
    clr_b = val[2*$bits(ctl_t)-1:$bits(ctl_t)];
    both  = set_b & clr_b;
    if (both != '0)
      update = cur ^ both;
    else
      update = (cur | set_b) & ~clr_b;
  endfunction

  ////////////////////
  // handshake

  // request not yet seen
  assign new_req  = frame_req && !frame_ack;
  assign soft_rst = new_req && (frame_addr == addr_soft_reset);

  // ack rises with the register write
  // falls once decode has let go of req
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      frame_ack <= 1'b0;
    else if (new_req)
      frame_ack <= 1'b1;
    else if (!frame_req)
      frame_ack <= 1'b0;
  end

  ////////////////////
  // registers

  // hard and soft reset load the same values
  always_ff @(posedge clk)
  begin
    if (!rst_n || soft_rst)
    begin
      led         <= rst_default;
      reg_mux     <= rst_default;
      dac         <= rst_default;
      rails       <= rst_default;
      dac_ref_mux <= rst_default;
      adc         <= rst_default;
      clamp1      <= rst_clamp1;
      clamp2      <= rst_clamp2;
      rails_oe    <= rst_rails_oe;
    end
    else if (new_req)
    begin
      case (frame_addr)
        addr_led:
          led <= update(led, frame_val);
        addr_mux:
          reg_mux <= update(reg_mux, frame_val);
        addr_dac:
          dac <= update(dac, frame_val);
        addr_rails:
          rails <= update(rails, frame_val);
        addr_dac_ref_mux:
          dac_ref_mux <= update(dac_ref_mux, frame_val);
        addr_adc:
          adc <= update(adc, frame_val);
        // clamps are active low, a set bit turns a switch off
        addr_clamp1:
          clamp1 <= update(clamp1, frame_val);
        addr_clamp2:
          clamp2 <= update(clamp2, frame_val);
        addr_rails_oe:
          rails_oe <= update(rails_oe, frame_val);
        // unknown address, no write
        // ack still goes out so the master is never stuck
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* spi_periph_route.sv */
/*
 * chip select fan-out and miso select for the shared spi bus
 */

`timescale 1ns/1ps
`default_nettype none

module spi_periph_route
  import smu_ctl_pkg::*;
#(
  parameter int n_periph = 4
)
(
  input  logic                cs_n,
  input  logic                special_n,
  input  ctl_t                reg_mux,
  input  logic [n_periph-1:0] periph_miso,
  output logic [n_periph-1:0] periph_cs_n,
  output logic                miso
);

  // one mux bit per peripheral, upper bits ignored for small n_periph
  logic [n_periph-1:0] sel;

  assign sel = reg_mux[n_periph-1:0];

  ////////////////////
  // chip select

  // special_n low means the fabric owns the bus
  // no peripheral may see that traffic
  always_comb
  begin
    if (special_n)
      periph_cs_n = ~(sel & {n_periph{~cs_n}});
    else
      periph_cs_n = '1;
  end

  ////////////////////
  // miso

  // wired-or of selected peripherals
  // several bits set is the master's problem
  always_comb
  begin
    if (special_n)
      miso = |(sel & periph_miso);
    else
      miso = 1'b0;
  end

endmodule

`default_nettype wire

/* smu_ctl_top.sv */
/*
 * top of the smu spi control bank
 * frame decode, register execute, peripheral routing
 */

`timescale 1ns/1ps
`default_nettype none

module smu_ctl_top
  import smu_ctl_pkg::*;
#(
  parameter int n_periph = 4
)
(
  input  logic                clk,
  input  logic                rst_n,

  // spi from the master
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                special_n,
  input  logic                mosi,
  output logic                miso,

  // shared spi bus to the peripherals
  output logic                periph_sclk,
  output logic                periph_mosi,
  output logic [n_periph-1:0] periph_cs_n,
  input  logic [n_periph-1:0] periph_miso,

  // control registers to board pins
  output ctl_t                led,
  output ctl_t                dac,
  output ctl_t                rails,
  output ctl_t                dac_ref_mux,
  output ctl_t                adc,
  output ctl_t                clamp1,
  output ctl_t                clamp2,
  output ctl_t                rails_oe
);

  logic  frame_req;
  logic  frame_ack;
  addr_t frame_addr;
  val_t  frame_val;
  ctl_t  reg_mux;

  ////////////////////
  // pass through

  // clock and data go to every peripheral, only cs is routed
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  ////////////////////
  // stages

  spi_frame_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .special_n  (special_n),
    .mosi       (mosi),
    .frame_ack  (frame_ack),
    .frame_req  (frame_req),
    .frame_addr (frame_addr),
    .frame_val  (frame_val)
  );

  ctl_reg_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_req   (frame_req),
    .frame_addr  (frame_addr),
    .frame_val   (frame_val),
    .frame_ack   (frame_ack),
    .reg_mux     (reg_mux),
    .led         (led),
    .dac         (dac),
    .rails       (rails),
    .dac_ref_mux (dac_ref_mux),
    .adc         (adc),
    .clamp1      (clamp1),
    .clamp2      (clamp2),
    .rails_oe    (rails_oe)
  );

  // raw pins, no sync, routing is purely combinational
  spi_periph_route #(
    .n_periph (n_periph)
  ) u_route (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .reg_mux     (reg_mux),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
 * testbench clock and reset generator
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 2
)
(
  output logic clk,
  output logic rst_n
);

  // free running clock, starts low
  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset released just after a rising edge, like every other input
  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #5;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* smu_ctl_tb.sv */
/*
 * directed testbench for the smu spi control bank
 * spi driver, reference register model, checks, timeout
 */

`timescale 1ns/1ps
`default_nettype none

module smu_ctl_tb
  import smu_ctl_pkg::*;
();

  // ~29 frames of ~150 cycles each, limit leaves about 4x margin
  localparam int max_cycles  = 20000;
  localparam int drive_delay = 5;
  localparam int half_bit    = 4;
  localparam int frame_gap   = 10;

  // model slots
  localparam int i_led      = 0;
  localparam int i_mux      = 1;
  localparam int i_dac      = 2;
  localparam int i_rails    = 3;
  localparam int i_dref     = 4;
  localparam int i_adc      = 5;
  localparam int i_clamp1   = 6;
  localparam int i_clamp2   = 7;
  localparam int i_rails_oe = 8;

  // register map as the master sees it
  localparam logic [7:0] reg_addr [9] =
    '{8'd7, 8'd8, 8'd9, 8'd10, 8'd12, 8'd14, 8'd15, 8'd16, 8'd24};

  logic       clk;
  logic       rst_n;
  logic       sclk;
  logic       cs_n;
  logic       special_n;
  logic       mosi;
  logic       miso;
  logic       periph_sclk;
  logic       periph_mosi;
  logic [3:0] periph_cs_n;
  logic [3:0] periph_miso;
  ctl_t       led, dac, rails, dac_ref_mux, adc, clamp1, clamp2, rails_oe;

  ctl_t model [9];
  int   errors = 0;
  int   checks = 0;
  int   cycle_cnt = 0;

  tb_clk_gen #(
    .period_ns    (40),
    .reset_cycles (2)
  ) u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  smu_ctl_top #(
    .n_periph (4)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .miso        (miso),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso),
    .led         (led),
    .dac         (dac),
    .rails       (rails),
    .dac_ref_mux (dac_ref_mux),
    .adc         (adc),
    .clamp1      (clamp1),
    .clamp2      (clamp2),
    .rails_oe    (rails_oe)
  );

  // hard stop if a test hangs
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles)
    begin
      $display("timeout: the tests did not finish within %0d clock cycles", max_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////
  // helpers

  // returns just after a rising edge, inputs change here
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #(drive_delay);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
  endtask

  ////////////////////
  // reference model

  task automatic model_reset();
    for (int i = 0; i < 9; i++)
      model[i] = 4'h0;
    // clamps active low, rails output enable held off
    model[i_clamp1]   = 4'hf;
    model[i_clamp2]   = 4'hf;
    model[i_rails_oe] = 4'h1;
  endtask

  // bit by bit, any set+clear pair turns the frame into a toggle
  function automatic ctl_t model_update(input ctl_t cur, input logic [7:0] val);
    ctl_t nxt;
    logic toggling;
    toggling = 1'b0;
    for (int i = 0; i < 4; i++)
      if (val[i] && val[i+4])
        toggling = 1'b1;
    nxt = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (toggling)
      begin
        if (val[i] && val[i+4])
          nxt[i] = ~cur[i];
      end
      else if (val[i+4])
        nxt[i] = 1'b0;
      else if (val[i])
        nxt[i] = 1'b1;
    end
    return nxt;
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] val);
    if (addr == 8'd11)
      model_reset();
    else
      for (int i = 0; i < 9; i++)
        if (reg_addr[i] == addr)
          model[i] = model_update(model[i], val);
  endtask

  ////////////////////
  // spi driver

  // low bits of word, msb first, then cs_n release and a quiet gap
  task automatic shift_bits(input logic [15:0] word, input int nbits, input logic spec);
    int i;
    special_n = spec;
    sclk      = 1'b0;
    cs_n      = 1'b0;
    wait_cycles(half_bit);
    for (i = nbits - 1; i >= 0; i--)
    begin
      mosi = word[i];
      sclk = 1'b0;
      wait_cycles(half_bit);
      sclk = 1'b1;
      wait_cycles(half_bit);
    end
    sclk = 1'b0;
    wait_cycles(half_bit);
    cs_n = 1'b1;
    wait_cycles(frame_gap);
    special_n = 1'b1;
    mosi      = 1'b0;
    wait_cycles(1);
  endtask

  task automatic send_cmd(input logic [7:0] addr, input logic [7:0] val);
    shift_bits({addr, val}, 16, 1'b0);
    model_write(addr, val);
  endtask

  // mux has no pin of its own, read it through the chip selects
  task automatic check_regs(input string tag);
    check(led, model[i_led], {tag, ": led"});
    check(dac, model[i_dac], {tag, ": dac"});
    check(rails, model[i_rails], {tag, ": rails"});
    check(dac_ref_mux, model[i_dref], {tag, ": dac_ref_mux"});
    check(adc, model[i_adc], {tag, ": adc"});
    check(clamp1, model[i_clamp1], {tag, ": clamp1"});
    check(clamp2, model[i_clamp2], {tag, ": clamp2"});
    check(rails_oe, model[i_rails_oe], {tag, ": rails_oe"});
    special_n = 1'b1;
    cs_n      = 1'b0;
    wait_cycles(1);
    check(periph_cs_n, ctl_t'(~model[i_mux]), {tag, ": mux via periph_cs_n"});
    cs_n = 1'b1;
    wait_cycles(1);
  endtask

  ////////////////////
  // tests

  task automatic test_reset();
    int e0;
    e0 = errors;
    check_regs("after reset");
    check(periph_cs_n, 4'hf, "periph_cs_n idle after reset");
    report_test(1, "reset values", e0);
  endtask

  task automatic test_set_clear();
    int e0;
    logic [31:0] r;
    ctl_t set_b;
    ctl_t clr_b;
    e0 = errors;
    for (int i = 0; i < 9; i++)
      for (int k = 0; k < 2; k++)
      begin
        r     = $urandom;
        set_b = r[3:0];
        // drop overlap so this stays a plain set/clear
        clr_b = r[7:4] & ~r[3:0];
        send_cmd(reg_addr[i], {clr_b, set_b});
        check_regs($sformatf("set/clear at address %0d", reg_addr[i]));
      end
    report_test(2, "set and clear", e0);
  endtask

  task automatic test_toggle();
    int e0;
    ctl_t start;
    e0 = errors;
    // set 0111 clear 0110, bits 2..1 flip, bit 0 set is ignored
    start = model[i_dac];
    send_cmd(8'd9, 8'h67);
    check_regs("dac first toggle");
    check(dac, start ^ 4'b0110, "dac flipped once");
    send_cmd(8'd9, 8'h67);
    check(dac, start, "dac back to start");
    // outer bits of rails_oe
    start = model[i_rails_oe];
    send_cmd(8'd24, 8'h99);
    check_regs("rails_oe first toggle");
    check(rails_oe, start ^ 4'b1001, "rails_oe flipped once");
    send_cmd(8'd24, 8'h99);
    check(rails_oe, start, "rails_oe back to start");
    report_test(3, "toggle", e0);
  endtask

  task automatic test_soft_reset();
    int e0;
    e0 = errors;
    send_cmd(8'd7, 8'h0a);
    send_cmd(8'd11, 8'h00);
    check_regs("soft reset");
    send_cmd(8'd7, 8'h05);
    // address 13 is a hole in the map
    // value low nibble zero, leaves the shifter top nibble clear
    send_cmd(8'd13, 8'hf0);
    check_regs("unused address");
    // short frame, would hit led if accepted
    shift_bits(16'h070f, 12, 1'b0);
    check_regs("12-bit frame");
    report_test(4, "soft reset and ignored frames", e0);
  endtask

  task automatic test_mux_route();
    int e0;
    logic [3:0] pm [5];
    logic exp_miso [5];
    e0 = errors;
    pm = '{4'b0001, 4'b0100, 4'b1010, 4'b1111, 4'b0000};
    exp_miso = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    // clear 1010 set 0101
    send_cmd(8'd8, 8'ha5);
    check_regs("mux 0101");
    special_n = 1'b1;
    cs_n      = 1'b0;
    wait_cycles(1);
    check(periph_cs_n, 4'b1010, "periph_cs_n with mux 0101");
    for (int i = 0; i < 5; i++)
    begin
      periph_miso = pm[i];
      wait_cycles(1);
      check(miso, exp_miso[i], $sformatf("miso with periph_miso %b", pm[i]));
    end
    // clock and data reach the peripherals unchanged
    sclk = 1'b1;
    mosi = 1'b0;
    wait_cycles(1);
    check(periph_sclk, 1'b1, "periph_sclk high");
    check(periph_mosi, 1'b0, "periph_mosi low");
    sclk = 1'b0;
    mosi = 1'b1;
    wait_cycles(1);
    check(periph_sclk, 1'b0, "periph_sclk low");
    check(periph_mosi, 1'b1, "periph_mosi high");
    mosi = 1'b0;
    // fabric frame, peripherals locked out
    special_n   = 1'b0;
    periph_miso = 4'b1111;
    wait_cycles(1);
    check(periph_cs_n, 4'b1111, "periph_cs_n with special_n low");
    check(miso, 1'b0, "miso with special_n low");
    cs_n        = 1'b1;
    special_n   = 1'b1;
    periph_miso = 4'b0000;
    wait_cycles(1);
    report_test(5, "peripheral routing", e0);
  endtask

  task automatic test_special_high();
    int e0;
    e0 = errors;
    // would invert led if decode took it
    shift_bits({8'd7, model[i_led], ~model[i_led]}, 16, 1'b1);
    check_regs("frame with special_n high");
    report_test(6, "frame to peripherals", e0);
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    void'($urandom(32'h8938));
    sclk        = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    periph_miso = 4'b0000;
    model_reset();
    @(posedge rst_n);
    wait_cycles(2);
    test_reset();
    test_set_clear();
    test_toggle();
    test_soft_reset();
    test_mux_route();
    test_special_high();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
smu_ctl_pkg.sv
spi_frame_decode.sv
ctl_reg_execute.sv
spi_periph_route.sv
smu_ctl_top.sv
tb_clk_gen.sv
smu_ctl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the smu control bank testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module smu_ctl_tb -f build.f -o smu_ctl_sim \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/smu_ctl_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
